// File: tb/stream_mux_tests.txt
# name op a b exp (decimal); stall a=in% b=out%, hold a, wr a=addr b=data, rd a=addr exp
# cmd a=vfid b=len, drain exp=beats since last drain, full exp=cmd_full; addr 0 enable 1 drops 2 beats
reset_en    rd    0  0  15
single      cmd   2  3  0
single_end  drain 0  0  4
b2b_a       cmd   0  1  0
b2b_b       cmd   1  4  0
b2b_c       cmd   3  0  0
b2b_end     drain 0  0  8
rand_on     stall 30 40 0
rand_a      cmd   1  15 0
rand_b      cmd   2  7  0
rand_c      cmd   0  31 0
rand_end    drain 0  0  56
beats_rd    rd    2  0  68
mask_wr     wr    0  5  0
mask_a      cmd   1  3  0
mask_b      cmd   0  2  0
mask_c      cmd   3  5  0
mask_d      cmd   2  1  0
mask_end    drain 0  0  5
drops_rd    rd    1  0  2
clr_beats   wr    2  0  0
clr_drops   wr    1  0  0
clr_rd      rd    1  0  0
unmask      wr    0  15 0
hold_on     hold  1  0  0
fill_0      cmd   0  0  0
fill_1      cmd   1  1  0
fill_2      cmd   2  2  0
fill_3      cmd   3  0  0
fill_4      cmd   0  1  0
fill_5      cmd   1  2  0
fill_6      cmd   2  0  0
fill_7      cmd   3  1  0
fill_8      cmd   0  2  0
fill_full   full  0  0  1
hold_off    hold  0  0  0
fill_end    drain 0  0  18
fill_free   full  0  0  0
recount_rd  rd    2  0  18

// File: flist.f
design/stream_mux_pkg.sv
design/mux_cmd_queue.sv
design/mux_cfg_regs.sv
design/axis_mux_sink.sv
design/stream_mux_top.sv
tb/stream_mux_assertions.sv
tb/stream_mux_tb.sv

// File: Bender.yml
package:
  name: stream_mux

sources:
  - files:
      - design/stream_mux_pkg.sv
      - design/mux_cmd_queue.sv
      - design/mux_cfg_regs.sv
      - design/axis_mux_sink.sv
      - design/stream_mux_top.sv
  - target: test
    files:
      - tb/stream_mux_assertions.sv
      - tb/stream_mux_tb.sv

// File: tb/stream_mux_tb.sv
// Reads tb/stream_mux_tests.txt from the project root; enable changes are only made after a drain
`timescale 1ns/1ps

module stream_mux_tb;

  localparam int N = stream_mux_pkg::N_CHAN;

  logic                                 aclk;
  logic                                 aresetn;
  logic                                 cmd_valid;
  stream_mux_pkg::mux_cmd_t             cmd;
  logic                                 cmd_full;
  logic [N-1:0]                         in_valid;
  stream_mux_pkg::stream_beat_t [N-1:0] in_beat;
  logic [N-1:0]                         in_ready;
  logic                                 out_valid;
  stream_mux_pkg::stream_beat_t         out_beat;
  logic                                 out_ready;
  logic                                 out_last;
  logic                                 cfg_wr;
  logic                                 cfg_rd;
  stream_mux_pkg::reg_addr_t            cfg_addr;
  stream_mux_pkg::reg_data_t            cfg_wdata;
  stream_mux_pkg::reg_data_t            cfg_rdata;

  // Records from the tests file
  string rec_name [$];
  string rec_op   [$];
  int    rec_a    [$];
  int    rec_b    [$];
  int    rec_exp  [$];

  // Reference model holding one entry per predicted output beat
  logic [63:0]                exp_data [$];
  logic                       exp_last [$];
  int                         mdl_seq  [N];
  stream_mux_pkg::chan_mask_t mdl_mask;

  // Producer sequence numbers and stall control
  int     prod_seq [N];
  int     in_stall;
  int     out_stall;
  logic   hold;
  integer seed;
  int     beats_seen;
  int     limit_cycles;
  string  cur_name;

  stream_mux_top dut0 (.*);

  bind axis_mux_sink stream_mux_assertions asrt0 (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %0h actual %0h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped on mismatch");
    end
  endtask

  // --------------------
  // Model and drivers
  // --------------------

  // Enabled command yields len+1 beats of that channel with last on the final one
  task automatic expect_cmd(input int vfid, input int len);
    if (mdl_mask[vfid]) begin
      for (int i = 0; i <= len; i++) begin
        exp_data.push_back((64'(vfid) << 32) | 64'(mdl_seq[vfid]));
        exp_last.push_back(i == len);
        mdl_seq[vfid]++;
      end
    end
  endtask

  task automatic push_cmd(input int vfid, input int len);
    while (cmd_full) begin
      @(negedge aclk);
    end
    cmd_valid = 1'b1;
    cmd.vfid  = stream_mux_pkg::chan_id_t'(vfid);
    cmd.len   = stream_mux_pkg::beat_len_t'(len);
    expect_cmd(vfid, len);
    @(negedge aclk);
    cmd_valid = 1'b0;
  endtask

  task automatic cfg_access(input logic wr, input int addr, input int data);
    cfg_wr    = wr;
    cfg_rd    = !wr;
    cfg_addr  = stream_mux_pkg::reg_addr_t'(addr);
    cfg_wdata = stream_mux_pkg::reg_data_t'(data);
    @(negedge aclk);
    cfg_wr = 1'b0;
    cfg_rd = 1'b0;
  endtask

  // Wait for an empty queue, an idle FSM and no beat outstanding
  task automatic drain_check(input int exp_beats);
    while (exp_data.size() != 0 || dut0.cmd_q0.avail ||
           dut0.mux0.state_q != stream_mux_pkg::ST_IDLE) begin
      @(negedge aclk);
    end
    check_value(cur_name, 64'(exp_beats), 64'(beats_seen));
    beats_seen = 0;
  endtask

  // Producer data is {channel, sequence} with random stalls
  always @(negedge aclk) begin
    for (int c = 0; c < N; c++) begin
      in_valid[c]     = (({$random(seed)} % 100) >= in_stall);
      in_beat[c].data = (64'(c) << 32) | 64'(prod_seq[c]);
      in_beat[c].keep = '1;
    end
    out_ready = !hold && (({$random(seed)} % 100) >= out_stall);
  end

  // --------------------
  // Monitor
  // --------------------

  always @(posedge aclk) begin
    logic [N-1:0] allowed;
    allowed = '0;
    if (dut0.mux0.asrt0.err_cnt != 0) begin
      abort_run("A bound assertion on the mux failed");
    end else if (aresetn) begin
      // Only the channel owning the oldest predicted beat may be ready
      if (exp_data.size() != 0) begin
        allowed[exp_data[0][33:32]] = 1'b1;
      end
      check_value({cur_name, " in_ready"}, 64'(0), 64'(in_ready & ~allowed));
      for (int c = 0; c < N; c++) begin
        if (in_valid[c] && in_ready[c]) begin
          prod_seq[c]++;
        end
      end
      if (out_valid && out_ready) begin
        if (exp_data.size() == 0) begin
          abort_run("Output beat seen while no transfer was pending");
        end else begin
          check_value({cur_name, " data"}, exp_data[0], out_beat.data);
          check_value({cur_name, " last"}, 64'(exp_last[0]), 64'(out_last));
          check_value({cur_name, " keep"}, 64'hff, 64'(out_beat.keep));
          void'(exp_data.pop_front());
          void'(exp_last.pop_front());
          beats_seen++;
        end
      end
    end
  end

  // Watchdog sized from the loaded records
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge aclk);
    abort_run("Run hung, the watchdog expired before the last record finished");
  end

  // --------------------
  // Record sequencer
  // --------------------

  initial begin
    int    fd;
    string line;
    string nm;
    string op;
    int    a;
    int    b;
    int    e;
    int    total;
    seed         = 34;
    aresetn      = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    in_valid     = '0;
    in_beat      = '0;
    out_ready    = 1'b0;
    cfg_wr       = 1'b0;
    cfg_rd       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    hold         = 1'b0;
    in_stall     = 0;
    out_stall    = 0;
    beats_seen   = 0;
    limit_cycles = 0;
    mdl_mask     = '1;
    cur_name     = "reset";
    total        = 20;
    for (int c = 0; c < N; c++) begin
      mdl_seq[c]  = 0;
      prod_seq[c] = 0;
    end
    fd = $fopen("tb/stream_mux_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open tb/stream_mux_tests.txt");
    end
    // Lines starting with # are column notes
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%s %s %d %d %d", nm, op, a, b, e) == 5) begin
        rec_name.push_back(nm);
        rec_op.push_back(op);
        rec_a.push_back(a);
        rec_b.push_back(b);
        rec_exp.push_back(e);
        total += (op == "cmd") ? 200 + b + 1 : 200;
      end
    end
    $fclose(fd);
    limit_cycles = total;
    repeat (8) @(negedge aclk);
    aresetn = 1'b1;
    for (int i = 0; i < rec_op.size(); i++) begin
      cur_name = rec_name[i];
      case (rec_op[i])
        // Knobs move on the rising edge, away from the producer update
        "stall": begin
          @(posedge aclk);
          in_stall  = rec_a[i];
          out_stall = rec_b[i];
          @(negedge aclk);
        end
        "hold": begin
          @(posedge aclk);
          hold = (rec_a[i] != 0);
          @(negedge aclk);
        end
        "cmd":   push_cmd(rec_a[i], rec_b[i]);
        "drain": drain_check(rec_exp[i]);
        "full":  check_value(cur_name, 64'(rec_exp[i]), 64'(cmd_full));
        "wr": begin
          cfg_access(1'b1, rec_a[i], rec_b[i]);
          if (rec_a[i] == int'(stream_mux_pkg::REG_ENABLE)) begin
            mdl_mask = stream_mux_pkg::chan_mask_t'(rec_b[i]);
          end
        end
        "rd": begin
          cfg_access(1'b0, rec_a[i], 0);
          check_value(cur_name, 64'(rec_exp[i]), 64'(cfg_rdata));
        end
        default: abort_run({"Unknown operation in tests file: ", rec_op[i]});
      endcase
    end
    repeat (4) @(negedge aclk);
    if (dut0.mux0.asrt0.err_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Bound assertion failures at end of run");
    end
  end

endmodule

// File: tb/stream_mux_assertions.sv
// Bound into axis_mux_sink; every check but the reset check is off while aresetn is low
`timescale 1ns/1ps

module stream_mux_assertions (
  input logic                              aclk,
  input logic                              aresetn,
  input logic [stream_mux_pkg::N_CHAN-1:0] in_ready,
  input logic                              out_valid,
  input logic                              out_last,
  input stream_mux_pkg::mux_state_t        state_q
);

  // Failed assertion count
  int err_cnt = 0;

  // At most one producer is ever granted
  a_one_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(in_ready))
    else begin
      $error("More than one in_ready high");
      err_cnt++;
    end

  // Last flag only travels with a beat
  a_last_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    out_last |-> out_valid)
    else begin
      $error("out_last without out_valid");
      err_cnt++;
    end

  // Idle output stays quiet
  a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    (state_q == stream_mux_pkg::ST_IDLE) |-> (!out_valid && in_ready == '0))
    else begin
      $error("Output or grant active in ST_IDLE");
      err_cnt++;
    end

  // Reset leaves the FSM idle with no grant
  a_reset_idle: assert property (@(posedge aclk)
    !aresetn |=> (state_q == stream_mux_pkg::ST_IDLE && in_ready == '0))
    else begin
      $error("Mux not idle after reset");
      err_cnt++;
    end

endmodule

// File: design/stream_mux_top.sv
// Top of the command-steered stream mux; commands offered while cmd_full is high are lost
`timescale 1ns/1ps

module stream_mux_top (
  input  logic                                                   aclk,
  input  logic                                                   aresetn,
  // Command input
  input  logic                                                   cmd_valid,
  input  stream_mux_pkg::mux_cmd_t                               cmd,
  output logic                                                   cmd_full,
  // Producer streams
  input  logic [stream_mux_pkg::N_CHAN-1:0]                      in_valid,
  input  stream_mux_pkg::stream_beat_t [stream_mux_pkg::N_CHAN-1:0] in_beat,
  output logic [stream_mux_pkg::N_CHAN-1:0]                      in_ready,
  // Output stream
  output logic                                                   out_valid,
  output stream_mux_pkg::stream_beat_t                           out_beat,
  input  logic                                                   out_ready,
  output logic                                                   out_last,
  // Configuration port
  input  logic                                                   cfg_wr,
  input  logic                                                   cfg_rd,
  input  stream_mux_pkg::reg_addr_t                              cfg_addr,
  input  stream_mux_pkg::reg_data_t                              cfg_wdata,
  output stream_mux_pkg::reg_data_t                              cfg_rdata
);

  // Queue to mux
  logic                       cmd_avail;
  logic                       cmd_pop;
  stream_mux_pkg::mux_cmd_t   cmd_head;

  // Mux to and from registers
  stream_mux_pkg::chan_mask_t chan_enable;
  logic                       drop_pulse;
  logic                       beat_pulse;

  // --------------------
  // Command queue
  // --------------------

  mux_cmd_queue cmd_q0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .push     (cmd_valid),
    .push_cmd (cmd),
    .full     (cmd_full),
    .pop      (cmd_pop),
    .avail    (cmd_avail),
    .head     (cmd_head)
  );

  // --------------------
  // Registers
  // --------------------

  mux_cfg_regs cfg0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .chan_enable (chan_enable),
    .drop_pulse  (drop_pulse),
    .beat_pulse  (beat_pulse)
  );

  // Stream mux
  axis_mux_sink mux0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_avail   (cmd_avail),
    .cmd_head    (cmd_head),
    .cmd_pop     (cmd_pop),
    .chan_enable (chan_enable),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_beat    (out_beat),
    .out_ready   (out_ready),
    .out_last    (out_last),
    .drop_pulse  (drop_pulse),
    .beat_pulse  (beat_pulse)
  );

endmodule

// File: design/axis_mux_sink.sv
// Command-steered N-to-1 stream mux; input tlast is not used and out_last comes from the beat count
`timescale 1ns/1ps

module axis_mux_sink (
  input  logic                                                   aclk,
  input  logic                                                   aresetn,
  // Command head from the queue
  input  logic                                                   cmd_avail,
  input  stream_mux_pkg::mux_cmd_t                               cmd_head,
  output logic                                                   cmd_pop,
  // Channel mask from the register block
  input  stream_mux_pkg::chan_mask_t                             chan_enable,
  // Producer streams
  input  logic [stream_mux_pkg::N_CHAN-1:0]                      in_valid,
  input  stream_mux_pkg::stream_beat_t [stream_mux_pkg::N_CHAN-1:0] in_beat,
  output logic [stream_mux_pkg::N_CHAN-1:0]                      in_ready,
  // Output stream
  output logic                                                   out_valid,
  output stream_mux_pkg::stream_beat_t                           out_beat,
  input  logic                                                   out_ready,
  output logic                                                   out_last,
  // Statistics
  output logic                                                   drop_pulse,
  output logic                                                   beat_pulse
);

  // FSM and grant
  stream_mux_pkg::mux_state_t state_q;
  stream_mux_pkg::mux_state_t state_d;
  stream_mux_pkg::chan_id_t   id_q;
  stream_mux_pkg::chan_id_t   id_d;
  stream_mux_pkg::beat_len_t  cnt_q;
  stream_mux_pkg::beat_len_t  cnt_d;

  // Handshake helpers
  logic granted;
  logic xfer;
  logic last_xfer;
  logic head_enabled;

  // --------------------
  // Datapath
  // --------------------

  assign granted = (state_q == stream_mux_pkg::ST_MUX);

  // Only the owner sees out_ready, so stalls pass straight through
  always_comb begin
    in_ready = '0;
    if (granted) begin
      in_ready[id_q] = out_ready;
    end
  end

  // Zero payload while nobody owns the output
  always_comb begin
    if (granted) begin
      out_valid = in_valid[id_q];
      out_beat  = in_beat[id_q];
    end else begin
      out_valid = 1'b0;
      out_beat  = '0;
    end
  end

  // Last flag from the remaining count, only alongside a valid beat
  assign out_last = granted && (cnt_q == '0) && out_valid;

  assign xfer      = out_valid & out_ready;
  assign last_xfer = xfer && (cnt_q == '0);

  // --------------------
  // Command intake
  // --------------------

  // Pop when idle, or on the final beat for a gapless hand-over
  assign cmd_pop      = cmd_avail && (!granted || last_xfer);
  assign head_enabled = chan_enable[cmd_head.vfid];

  // Disabled channel, command is swallowed
  assign drop_pulse = cmd_pop && !head_enabled;
  assign beat_pulse = xfer;

  // Next state and counters
  always_comb begin
    state_d = state_q;
    id_d    = id_q;
    cnt_d   = cnt_q;
    if (cmd_pop) begin
      // New owner, or back to idle if masked off
      state_d = head_enabled ? stream_mux_pkg::ST_MUX : stream_mux_pkg::ST_IDLE;
      id_d    = cmd_head.vfid;
      cnt_d   = cmd_head.len;
    end else if (last_xfer) begin
      state_d = stream_mux_pkg::ST_IDLE;
    end else if (xfer) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= stream_mux_pkg::ST_IDLE;
      id_q    <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// File: design/mux_cfg_regs.sv
// Config registers; read data appears one cycle after cfg_rd and a pulse coinciding with a clear is lost
`timescale 1ns/1ps

module mux_cfg_regs (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       cfg_wr,
  input  logic                       cfg_rd,
  input  stream_mux_pkg::reg_addr_t  cfg_addr,
  input  stream_mux_pkg::reg_data_t  cfg_wdata,
  output stream_mux_pkg::reg_data_t  cfg_rdata,
  output stream_mux_pkg::chan_mask_t chan_enable,
  input  logic                       drop_pulse,
  input  logic                       beat_pulse
);

  // Statistics counters
  stream_mux_pkg::stat_cnt_t drop_cnt;
  stream_mux_pkg::stat_cnt_t beat_cnt;

  // Decoded write strobes
  logic wr_enable;
  logic wr_drops;
  logic wr_beats;

  assign wr_enable = cfg_wr && (cfg_addr == stream_mux_pkg::REG_ENABLE);
  assign wr_drops  = cfg_wr && (cfg_addr == stream_mux_pkg::REG_DROPS);
  assign wr_beats  = cfg_wr && (cfg_addr == stream_mux_pkg::REG_BEATS);

  // --------------------
  // Writable state
  // --------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      // All channels open out of reset
      chan_enable <= '1;
    end else if (wr_enable) begin
      chan_enable <= cfg_wdata[stream_mux_pkg::N_CHAN-1:0];
    end
  end

  // Dropped command count, any write clears
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      drop_cnt <= '0;
    end else if (wr_drops) begin
      drop_cnt <= '0;
    end else if (drop_pulse) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  // Forwarded beat count, wraps silently
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (wr_beats) begin
      beat_cnt <= '0;
    end else if (beat_pulse) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // Registered, held until the next read
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_rdata <= '0;
    end else if (cfg_rd) begin
      case (cfg_addr)
        stream_mux_pkg::REG_ENABLE: cfg_rdata <= stream_mux_pkg::reg_data_t'(chan_enable);
        stream_mux_pkg::REG_DROPS:  cfg_rdata <= stream_mux_pkg::reg_data_t'(drop_cnt);
        stream_mux_pkg::REG_BEATS:  cfg_rdata <= stream_mux_pkg::reg_data_t'(beat_cnt);
        default:                    cfg_rdata <= '0;
      endcase
    end
  end

endmodule

// File: design/mux_cmd_queue.sv
// Command FIFO; a push while full is dropped and a pop while empty is ignored
`timescale 1ns/1ps

module mux_cmd_queue (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     push,
  input  stream_mux_pkg::mux_cmd_t push_cmd,
  output logic                     full,
  input  logic                     pop,
  output logic                     avail,
  output stream_mux_pkg::mux_cmd_t head
);

  // Entry storage
  stream_mux_pkg::mux_cmd_t mem [stream_mux_pkg::CMD_DEPTH];

  // Pointers and fill level
  stream_mux_pkg::cmd_ptr_t wr_ptr;
  stream_mux_pkg::cmd_ptr_t rd_ptr;
  stream_mux_pkg::cmd_cnt_t count;

  // Qualified strobes
  logic do_push;
  logic do_pop;

  // --------------------
  // Status
  // --------------------

  assign full  = (count == stream_mux_pkg::CMD_FULL);
  assign avail = (count != '0);

  // Only accept what fits, only release what exists
  assign do_push = push & ~full;
  assign do_pop  = pop & avail;

  // Head seen by the mux straight from the read slot
  assign head = mem[rd_ptr];

  // --------------------
  // Pointers
  // --------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at the last slot
        wr_ptr <= (wr_ptr == stream_mux_pkg::CMD_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == stream_mux_pkg::CMD_PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the level unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

endmodule

// File: design/stream_mux_pkg.sv
// Shared widths, types and register map; N_CHAN and CMD_DEPTH are assumed to be powers of two
package stream_mux_pkg;

  // --------------------
  // Sizes
  // --------------------

  // Producer channels and channel index width
  localparam int N_CHAN    = 4;
  localparam int CHAN_BITS = $clog2(N_CHAN);

  // Beat payload
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8;

  // Command length, stored as beats minus one
  localparam int LEN_BITS = 8;

  // Command queue sizing
  localparam int CMD_DEPTH    = 8;
  localparam int CMD_PTR_BITS = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_BITS = $clog2(CMD_DEPTH + 1);

  // Statistics and register port
  localparam int CNT_BITS      = 32;
  localparam int REG_ADDR_BITS = 2;
  localparam int REG_DATA_BITS = 32;

  // --------------------
  // Types
  // --------------------

  typedef logic [CHAN_BITS-1:0]     chan_id_t;
  typedef logic [LEN_BITS-1:0]      beat_len_t;
  typedef logic [CNT_BITS-1:0]      stat_cnt_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [REG_DATA_BITS-1:0] reg_data_t;
  typedef logic [N_CHAN-1:0]        chan_mask_t;

  // Queue pointer and occupancy
  typedef logic [CMD_PTR_BITS-1:0] cmd_ptr_t;
  typedef logic [CMD_CNT_BITS-1:0] cmd_cnt_t;

  // Last slot index and full level of the command queue
  localparam cmd_ptr_t CMD_PTR_LAST = cmd_ptr_t'(CMD_DEPTH - 1);
  localparam cmd_cnt_t CMD_FULL     = cmd_cnt_t'(CMD_DEPTH);

  // Register map
  localparam reg_addr_t REG_ENABLE = 2'd0;
  localparam reg_addr_t REG_DROPS  = 2'd1;
  localparam reg_addr_t REG_BEATS  = 2'd2;

  // Transfer command: target channel and beats minus one
  typedef struct packed {
    chan_id_t  vfid;
    beat_len_t len;
  } mux_cmd_t;

  // One stream beat
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
  } stream_beat_t;

  // Mux FSM
  typedef enum logic {
    ST_IDLE,
    ST_MUX
  } mux_state_t;

endpackage
